// ==== logic/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    ////////////////////////////////////////
    // i2s framing
    ////////////////////////////////////////

    localparam int sample_w  = 24;  // pcm word carried in each slot
    localparam int slot_bits = 32;  // bit clocks per channel slot

    ////////////////////////////////////////
    // fir arithmetic
    ////////////////////////////////////////

    localparam int coef_w    = 16;  // signed q1.15 coefficient
    localparam int acc_w     = 48;  // 40 bit product plus 8 guard bits for 256 taps
    localparam int out_shift = 15;  // drops the coefficient fraction bits

endpackage

`default_nettype wire

// ==== logic/i2s_rx.sv ====
`default_nettype none

module i2s_rx (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  i2s_bclk,
    input  logic                                  i2s_lrclk,
    input  logic                                  i2s_d,
    output logic                                  bclk_s,
    output logic                                  lrclk_s,
    output logic                                  data_s,
    output logic                                  l_stb,
    output logic                                  r_stb,
    output logic signed [audio_pkg::sample_w-1:0] l_sample,
    output logic signed [audio_pkg::sample_w-1:0] r_sample
);
    import audio_pkg::*;

    localparam int cnt_w = $clog2(slot_bits) + 1;  // room to saturate at slot_bits

    logic [2:0]          sync_a;     // first stage {bclk, lrclk, d}
    logic                bclk_d;     // previous synced bit clock
    logic                lrclk_d;    // previous synced word clock
    logic                bclk_rise;
    logic                lr_edge;
    logic                take_bit;
    logic [cnt_w-1:0]    bit_cnt;    // rising edges since last word clock edge
    logic [sample_w-1:0] shreg;

    ////////////////////////////////////////
    // two-flop synchronizers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_a                    <= '0;
            {bclk_s, lrclk_s, data_s} <= '0;
            bclk_d                    <= 1'b0;
            lrclk_d                   <= 1'b0;
        end else begin
            sync_a                    <= {i2s_bclk, i2s_lrclk, i2s_d};
            {bclk_s, lrclk_s, data_s} <= sync_a;  // same delay on all three lines
            bclk_d                    <= bclk_s;
            lrclk_d                   <= lrclk_s;
        end
    end

    assign bclk_rise = bclk_s & ~bclk_d;
    assign lr_edge   = lrclk_s ^ lrclk_d;

    // first rise after the edge is the one-bit i2s delay, then 24 data bits
    assign take_bit  = bclk_rise & ~lr_edge & (bit_cnt != '0) &
                       (bit_cnt <= cnt_w'(sample_w));

    ////////////////////////////////////////
    // deserializer
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt  <= '0;
            shreg    <= '0;
            l_stb    <= 1'b0;
            r_stb    <= 1'b0;
            l_sample <= '0;
            r_sample <= '0;
        end else begin
            l_stb <= lr_edge & lrclk_s;   // rising word clock closes left slot
            r_stb <= lr_edge & ~lrclk_s;  // falling one closes right slot
            if (lr_edge) begin
                bit_cnt <= '0;
                if (lrclk_s) begin
                    l_sample <= shreg;
                end else begin
                    r_sample <= shreg;
                end
            end else if (bclk_rise && bit_cnt != cnt_w'(slot_bits)) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (take_bit) begin
                shreg <= {shreg[sample_w-2:0], data_s};  // msb first
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/coef_ram.sv ====
`default_nettype none

module coef_ram #(
    parameter int num_taps = 64
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                we,
    input  logic [$clog2(num_taps)-1:0]         waddr,
    input  logic signed [audio_pkg::coef_w-1:0] wdata,
    input  logic [$clog2(num_taps)-1:0]         raddr_a,
    input  logic [$clog2(num_taps)-1:0]         raddr_b,
    output logic signed [audio_pkg::coef_w-1:0] rdata_a,
    output logic signed [audio_pkg::coef_w-1:0] rdata_b
);
    import audio_pkg::*;

    logic signed [coef_w-1:0] mem [num_taps];  // one word per tap

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_taps; i++) begin
                mem[i] <= '0;               // all-zero filter until loaded
            end
            rdata_a <= '0;
            rdata_b <= '0;
        end else begin
            if (we && (int'(waddr) < num_taps)) begin
                mem[waddr] <= wdata;        // host port, visible next cycle
            end
            rdata_a <= mem[raddr_a];        // left filter
            rdata_b <= mem[raddr_b];        // right filter
        end
    end

endmodule

`default_nettype wire

// ==== logic/fir_filter.sv ====
`default_nettype none

module fir_filter #(
    parameter int num_taps = 64
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  in_stb,
    input  logic signed [audio_pkg::sample_w-1:0] sample,
    input  logic signed [audio_pkg::coef_w-1:0]   coef_rdata,
    output logic [$clog2(num_taps)-1:0]           coef_raddr,
    output logic                                  out_stb,
    output logic signed [audio_pkg::sample_w-1:0] y
);
    import audio_pkg::*;

    localparam int                      addr_w = $clog2(num_taps);
    localparam int                      prod_w = sample_w + coef_w;
    localparam logic [addr_w:0]         taps_c = (addr_w + 1)'(num_taps);
    localparam logic [addr_w-1:0]       last_k = addr_w'(num_taps - 1);
    localparam logic signed [acc_w-1:0] y_max  = acc_w'(2 ** (sample_w - 1) - 1);
    localparam logic signed [acc_w-1:0] y_min  = -y_max - 1;

    logic signed [sample_w-1:0] dline [num_taps];  // circular delay line
    logic [addr_w-1:0]          head;         // newest entry x[n]
    logic [addr_w-1:0]          head_nxt;
    logic [addr_w-1:0]          k;            // tap being issued
    logic [addr_w:0]            rd_idx;       // head - k modulo num_taps
    logic                       busy;
    logic                       pend;         // sample waiting behind a busy run
    logic                       take;
    logic signed [sample_w-1:0] pend_sample;
    logic signed [sample_w-1:0] x_new;
    logic signed [sample_w-1:0] x_q;          // lines up with coef_rdata
    logic                       iss_v;
    logic                       iss_last;
    logic                       rd_v;
    logic                       rd_last;
    logic                       pr_v;
    logic                       pr_last;
    logic signed [prod_w-1:0]   prod;
    logic signed [acc_w-1:0]    acc;
    logic signed [acc_w-1:0]    sum_next;

    function automatic logic signed [sample_w-1:0] saturate(
        input logic signed [acc_w-1:0] v
    );
        logic signed [acc_w-1:0] s;
        s = v >>> out_shift;                // back to sample scale
        if (s > y_max) begin
            return y_max[sample_w-1:0];     // 0x7fffff
        end else if (s < y_min) begin
            return y_min[sample_w-1:0];     // 0x800000
        end
        return s[sample_w-1:0];
    endfunction

    assign take       = ~busy & (in_stb | pend);
    assign x_new      = pend ? pend_sample : sample;  // older sample goes first
    assign head_nxt   = (head == last_k) ? '0 : head + 1'b1;
    assign iss_last   = iss_v & (k == last_k);
    assign coef_raddr = k;
    assign rd_idx     = (head >= k) ? {1'b0, head} - {1'b0, k}
                                    : {1'b0, head} + taps_c - {1'b0, k};
    assign sum_next   = acc + acc_w'(prod);   // sign extended product

    ////////////////////////////////////////
    // sequencing and delay line
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_taps; i++) begin
                dline[i] <= '0;               // history before first sample is zero
            end
            head    <= '0;
            k       <= '0;
            busy    <= 1'b0;
            pend    <= 1'b0;
            iss_v   <= 1'b0;
            rd_v    <= 1'b0;
            rd_last <= 1'b0;
            pr_v    <= 1'b0;
            pr_last <= 1'b0;
            out_stb <= 1'b0;
        end else begin
            rd_v    <= iss_v;                 // coefficient read in flight
            rd_last <= iss_last;
            pr_v    <= rd_v;                  // product register stage
            pr_last <= rd_last;
            out_stb <= pr_last;               // num_taps + 3 after in_stb
            if (in_stb && (busy || pend)) begin
                pend <= 1'b1;
            end else if (take) begin
                pend <= 1'b0;
            end
            if (take) begin
                dline[head_nxt] <= x_new;
                head            <= head_nxt;
                busy            <= 1'b1;
                iss_v           <= 1'b1;
                k               <= '0;
            end else begin
                if (iss_last) begin
                    iss_v <= 1'b0;
                end else if (iss_v) begin
                    k <= k + 1'b1;
                end
                if (pr_last) begin
                    busy <= 1'b0;             // ready for the next sample
                end
            end
        end
    end

    ////////////////////////////////////////
    // multiply-accumulate datapath
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        x_q  <= dline[rd_idx[addr_w-1:0]];    // x[n-k]
        prod <= coef_rdata * x_q;             // c[k] * x[n-k]
        if (take) begin
            acc <= '0;
        end else if (pr_v) begin
            acc <= sum_next;
        end
        if (pr_last) begin
            y <= saturate(sum_next);          // last product folded in here
        end
        if (in_stb && (busy || pend)) begin
            pend_sample <= sample;
        end
    end

endmodule

`default_nettype wire

// ==== logic/i2s_tx.sv ====
`default_nettype none

module i2s_tx (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  bypass,
    input  logic                                  bclk_s,
    input  logic                                  lrclk_s,
    input  logic                                  data_s,
    input  logic                                  l_stb,
    input  logic signed [audio_pkg::sample_w-1:0] l_y,
    input  logic                                  r_stb,
    input  logic signed [audio_pkg::sample_w-1:0] r_y,
    output logic                                  dac_bclk,
    output logic                                  dac_lrclk,
    output logic                                  dac_data
);
    import audio_pkg::*;

    logic signed [sample_w-1:0] hold_l;     // latest left result
    logic signed [sample_w-1:0] hold_r;     // latest right result
    logic [sample_w-1:0]        next_word;
    logic [slot_bits-1:0]       shreg;
    logic                       bclk_q;
    logic                       lrclk_q;
    logic                       bclk_fall;
    logic                       lr_edge;
    logic                       skip;       // slot's own falling edge not seen yet
    logic                       tx_bit;

    assign bclk_fall = ~bclk_s & bclk_q;
    assign lr_edge   = lrclk_s ^ lrclk_q;
    assign next_word = lrclk_s ? hold_r : hold_l;  // high word clock opens right slot

    ////////////////////////////////////////
    // holding registers and serializer
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_l  <= '0;
            hold_r  <= '0;
            shreg   <= '0;
            bclk_q  <= 1'b0;
            lrclk_q <= 1'b0;
            skip    <= 1'b0;
            tx_bit  <= 1'b0;
        end else begin
            bclk_q  <= bclk_s;
            lrclk_q <= lrclk_s;
            if (l_stb) begin
                hold_l <= l_y;
            end
            if (r_stb) begin
                hold_r <= r_y;
            end
            if (lr_edge) begin
                shreg  <= {next_word, {(slot_bits - sample_w){1'b0}}};  // zero pad
                tx_bit <= 1'b0;                 // one-bit i2s delay
                skip   <= bclk_s;               // bit clock still high here
            end else if (bclk_fall) begin
                if (skip) begin
                    skip <= 1'b0;
                end else begin
                    tx_bit <= shreg[slot_bits-1];              // msb first
                    shreg  <= {shreg[slot_bits-2:0], 1'b0};
                end
            end
        end
    end

    ////////////////////////////////////////
    // dac outputs
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dac_bclk  <= 1'b0;
            dac_lrclk <= 1'b0;
            dac_data  <= 1'b0;
        end else begin
            dac_bclk  <= bclk_s;                   // clocks delayed in both modes
            dac_lrclk <= lrclk_s;
            dac_data  <= bypass ? data_s : tx_bit; // raw stream or filtered word
        end
    end

endmodule

`default_nettype wire

// ==== logic/audio_processing.sv ====
`default_nettype none

module audio_processing #(
    parameter int num_taps = 64
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                bypass,
    input  logic                                i2s_bclk,
    input  logic                                i2s_lrclk,
    input  logic                                i2s_d,
    input  logic                                coef_we,
    input  logic [$clog2(num_taps)-1:0]         coef_waddr,
    input  logic signed [audio_pkg::coef_w-1:0] coef_wdata,
    output logic                                dac_rst,
    output logic                                dac_bclk,
    output logic                                dac_lrclk,
    output logic                                dac_data
);
    import audio_pkg::*;

    localparam int addr_w = $clog2(num_taps);

    logic                       bclk_s;
    logic                       lrclk_s;
    logic                       data_s;
    logic                       l_stb;      // receiver to left fir
    logic                       r_stb;
    logic signed [sample_w-1:0] l_sample;
    logic signed [sample_w-1:0] r_sample;
    logic [addr_w-1:0]          l_raddr;
    logic [addr_w-1:0]          r_raddr;
    logic signed [coef_w-1:0]   l_coef;
    logic signed [coef_w-1:0]   r_coef;
    logic                       l_out_stb;  // left fir to transmitter
    logic                       r_out_stb;
    logic signed [sample_w-1:0] l_y;
    logic signed [sample_w-1:0] r_y;

    assign dac_rst = ~arst_n;  // dac held in reset with the system

    i2s_rx u_rx (
        .clk       (clk),
        .arst_n    (arst_n),
        .i2s_bclk  (i2s_bclk),
        .i2s_lrclk (i2s_lrclk),
        .i2s_d     (i2s_d),
        .bclk_s    (bclk_s),
        .lrclk_s   (lrclk_s),
        .data_s    (data_s),
        .l_stb     (l_stb),
        .r_stb     (r_stb),
        .l_sample  (l_sample),
        .r_sample  (r_sample)
    );

    coef_ram #(.num_taps(num_taps)) u_coef (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (coef_we),
        .waddr   (coef_waddr),
        .wdata   (coef_wdata),
        .raddr_a (l_raddr),     // port a serves left
        .raddr_b (r_raddr),
        .rdata_a (l_coef),
        .rdata_b (r_coef)
    );

    fir_filter #(.num_taps(num_taps)) fir_l (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_stb     (l_stb),
        .sample     (l_sample),
        .coef_rdata (l_coef),
        .coef_raddr (l_raddr),
        .out_stb    (l_out_stb),
        .y          (l_y)
    );

    fir_filter #(.num_taps(num_taps)) fir_r (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_stb     (r_stb),
        .sample     (r_sample),
        .coef_rdata (r_coef),
        .coef_raddr (r_raddr),
        .out_stb    (r_out_stb),
        .y          (r_y)
    );

    i2s_tx u_tx (
        .clk       (clk),
        .arst_n    (arst_n),
        .bypass    (bypass),
        .bclk_s    (bclk_s),
        .lrclk_s   (lrclk_s),
        .data_s    (data_s),
        .l_stb     (l_out_stb),
        .l_y       (l_y),
        .r_stb     (r_out_stb),
        .r_y       (r_y),
        .dac_bclk  (dac_bclk),
        .dac_lrclk (dac_lrclk),
        .dac_data  (dac_data)
    );

endmodule

`default_nettype wire

// ==== sim/tb_audio_processing.sv ====
`default_nettype none

module tb_audio_processing;
    import audio_pkg::*;

    localparam int     num_taps     = 8;
    localparam int     addr_w       = $clog2(num_taps);
    localparam int     n_impulse    = 10;
    localparam int     n_bypass     = 12;
    localparam int     n_random     = 40;
    localparam int     n_sat_old    = 6;   // frames before the coefficient rewrite
    localparam int     n_sat_new    = 8;
    localparam int     total_frames = n_impulse + n_bypass + n_random + n_sat_old + n_sat_new + 4;
    localparam int     frame_clks   = 2 * slot_bits * 8;  // bit clock period is 8 clk
    localparam longint full_pos     = (64'sd1 <<< (sample_w - 1)) - 1;
    localparam longint full_neg     = -full_pos - 1;

    logic                     clk;
    logic                     arst_n;
    logic                     bypass;
    logic                     i2s_bclk;
    logic                     i2s_lrclk;
    logic                     i2s_d;
    logic                     coef_we;
    logic [addr_w-1:0]        coef_waddr;
    logic signed [coef_w-1:0] coef_wdata;
    logic                     dac_rst;
    logic                     dac_bclk;
    logic                     dac_lrclk;
    logic                     dac_data;

    int                  check_errs;
    int                  other_errs;
    longint              coef_m [num_taps];  // mirror of the coefficient store
    longint              hist_l[$];          // every sample the left fir has taken
    longint              hist_r[$];
    logic [sample_w-1:0] exp_l[$];           // model output per closed slot
    logic [sample_w-1:0] exp_r[$];
    logic [sample_w-1:0] in_l[$];            // words sent in the current stream
    logic [sample_w-1:0] in_r[$];
    logic [sample_w-1:0] out_l[$];           // words rebuilt from the dac lines
    logic [sample_w-1:0] out_r[$];
    logic [sample_w-1:0] pend_l;             // slot word not yet closed by an edge
    logic [sample_w-1:0] pend_r;
    logic [sample_w-1:0] carry_l;            // last result of the previous stream
    logic [sample_w-1:0] carry_r;
    bit                  src_lr;             // word clock level the source drives
    bit                  dec_lr;
    bit                  dec_bclk;
    int                  dec_cnt;
    logic [sample_w-1:0] dec_word;

    audio_processing #(.num_taps(num_taps)) uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .bypass     (bypass),
        .i2s_bclk   (i2s_bclk),
        .i2s_lrclk  (i2s_lrclk),
        .i2s_d      (i2s_d),
        .coef_we    (coef_we),
        .coef_waddr (coef_waddr),
        .coef_wdata (coef_wdata),
        .dac_rst    (dac_rst),
        .dac_bclk   (dac_bclk),
        .dac_lrclk  (dac_lrclk),
        .dac_data   (dac_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #((longint'(total_frames) * frame_clks + 1000) * 100);
        $display("watchdog expired, the run hung before all tests finished");
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // dac side i2s decoder
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (dac_lrclk != dec_lr) begin  // word clock edge closes a slot
            if (dec_lr) begin
                out_r.push_back(dec_word);
            end else begin
                out_l.push_back(dec_word);
            end
            dec_lr  = dac_lrclk;
            dec_cnt = 0;
        end
        if (dac_bclk && !dec_bclk) begin
            if (dec_cnt >= 1 && dec_cnt <= sample_w) begin
                dec_word = {dec_word[sample_w-2:0], dac_data};  // msb first
            end
            if (dec_cnt < slot_bits) begin
                dec_cnt++;
            end
        end
        dec_bclk = dac_bclk;
    end

    ////////////////////////////////////////
    // model and helpers
    ////////////////////////////////////////

    task automatic compare_value(input logic [sample_w-1:0] got, input logic [sample_w-1:0] exp,
                                 input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            check_errs++;
        end
    endtask

    // y[n] = sat(sum c[k] x[n-k] >>> 15), zero history before the first sample
    function automatic logic [sample_w-1:0] filter_ref(input bit ch);
        longint acc;
        longint x;
        int     n;
        int     k;
        acc = 0;
        n   = ch ? hist_r.size() - 1 : hist_l.size() - 1;
        for (k = 0; k < num_taps; k++) begin
            if (n - k >= 0) begin
                x   = ch ? hist_r[n-k] : hist_l[n-k];
                acc = acc + coef_m[k] * x;
            end
        end
        acc = acc >>> out_shift;
        if (acc > full_pos) begin
            return full_pos[sample_w-1:0];
        end
        if (acc < full_neg) begin
            return full_neg[sample_w-1:0];
        end
        return acc[sample_w-1:0];
    endfunction

    task automatic write_coef(input int k, input logic [coef_w-1:0] v);
        @(negedge clk);
        coef_we    = 1'b1;
        coef_waddr = addr_w'(k);
        coef_wdata = v;
        coef_m[k]  = longint'($signed(v));
        @(negedge clk);
        coef_we    = 1'b0;
    endtask

    // the receiver strobes the ended channel at the word clock edge
    task automatic close_slot(input bit ch);
        if (ch) begin
            hist_r.push_back(longint'($signed(pend_r)));
            exp_r.push_back(filter_ref(1'b1));
        end else begin
            hist_l.push_back(longint'($signed(pend_l)));
            exp_l.push_back(filter_ref(1'b0));
        end
    endtask

    task automatic drive_slot(input bit ch, input logic [sample_w-1:0] w);
        int j;
        if (ch != src_lr) begin
            close_slot(src_lr);
        end
        src_lr = ch;
        if (ch) begin
            pend_r = w;
        end else begin
            pend_l = w;
        end
        for (j = 0; j < slot_bits; j++) begin
            @(negedge clk);
            i2s_bclk  = 1'b0;
            i2s_lrclk = ch;
            i2s_d     = (j >= 1 && j <= sample_w) ? w[sample_w-j] : 1'b0;  // one-bit delay
            repeat (4) @(negedge clk);
            i2s_bclk  = 1'b1;                  // dac samples on this rise
            repeat (3) @(negedge clk);
        end
    endtask

    task automatic send_frame(input logic [sample_w-1:0] l, input logic [sample_w-1:0] r);
        in_l.push_back(l);
        in_r.push_back(r);
        drive_slot(1'b0, l);
        drive_slot(1'b1, r);
    endtask

    task automatic start_stream();
        exp_l.delete();
        exp_r.delete();
        in_l.delete();
        in_r.delete();
        out_l.delete();
        out_r.delete();
    endtask

    // flush frame, then a last falling word clock edge so the right slot closes
    task automatic end_stream();
        send_frame('0, '0);
        if (src_lr) begin
            close_slot(1'b1);
        end
        src_lr = 1'b0;
        @(negedge clk);
        i2s_bclk  = 1'b0;
        i2s_lrclk = 1'b0;
        i2s_d     = 1'b0;
        repeat (24) @(negedge clk);
    endtask

    // the flush frame's results open the next stream
    task automatic save_carry();
        if (exp_l.size() > 0 && exp_r.size() > 0) begin
            carry_l = exp_l[$];
            carry_r = exp_r[$];
        end
    endtask

    // output frame k carries the result of input frame k-1
    task automatic verify_outputs(input string tag);
        int k;
        if (out_l.size() != exp_l.size() || out_r.size() != exp_r.size()) begin
            $display("%s: decoded %0d left and %0d right words, model has %0d and %0d",
                     tag, out_l.size(), out_r.size(), exp_l.size(), exp_r.size());
            other_errs++;
        end else if (out_l.size() > 0) begin
            compare_value(out_l[0], carry_l, $sformatf("%s left carried word", tag));
            compare_value(out_r[0], carry_r, $sformatf("%s right carried word", tag));
            for (k = 1; k < out_l.size(); k++) begin
                compare_value(out_l[k], exp_l[k-1], $sformatf("%s left frame %0d", tag, k - 1));
                compare_value(out_r[k], exp_r[k-1], $sformatf("%s right frame %0d", tag, k - 1));
            end
        end
        save_carry();
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic reset_behavior();
        repeat (2) @(negedge clk);
        compare_value(dac_rst, 1'b1, "dac_rst during reset");
        compare_value({dac_bclk, dac_lrclk, dac_data}, '0, "dac lines during reset");
        @(negedge clk);
        arst_n = 1'b1;                         // 3 rising edges held low
        repeat (6) @(negedge clk);
        compare_value(dac_rst, 1'b0, "dac_rst after reset");
        compare_value({dac_bclk, dac_lrclk, dac_data}, '0, "dac lines idle after reset");
    endtask

    task automatic impulse_response();
        int imp_c [num_taps] = '{16384, -8192, 4096, 32767, -32768, 1000, -1, 12345};
        int k;
        start_stream();
        for (k = 0; k < num_taps; k++) begin
            write_coef(k, 16'(imp_c[k]));
        end
        for (k = 0; k < n_impulse; k++) begin
            send_frame((k == 0) ? 24'h400000 : 24'h000000, 24'h000000);
        end
        end_stream();
        verify_outputs("impulse");
        if (out_l.size() == n_impulse + 1 && out_r.size() == n_impulse + 1) begin
            for (k = 1; k <= n_impulse; k++) begin
                // 2^22 * c >>> 15 is c * 128
                compare_value(out_l[k], (k <= num_taps) ? 24'(imp_c[k-1] * 128) : 24'h0,
                              $sformatf("impulse tap %0d", k - 1));
                compare_value(out_r[k], 24'h0, $sformatf("impulse right frame %0d", k - 1));
            end
        end
    endtask

    task automatic bypass_path();
        int k;
        start_stream();
        bypass = 1'b1;
        for (k = 0; k < n_bypass; k++) begin
            send_frame(24'($urandom), 24'($urandom));
        end
        end_stream();
        if (out_l.size() != in_l.size() || out_r.size() != in_r.size()) begin
            $display("bypass: decoded %0d words per channel, sent %0d", out_l.size(), in_l.size());
            other_errs++;
        end else begin
            for (k = 0; k < in_l.size(); k++) begin
                compare_value(out_l[k], in_l[k], $sformatf("bypass left frame %0d", k));
                compare_value(out_r[k], in_r[k], $sformatf("bypass right frame %0d", k));
            end
        end
        save_carry();                          // filters keep running under bypass
        bypass = 1'b0;
    endtask

    task automatic random_audio();
        int k;
        start_stream();
        for (k = 0; k < num_taps; k++) begin
            write_coef(k, 16'($urandom));
        end
        for (k = 0; k < n_random; k++) begin
            send_frame(24'($urandom), 24'($urandom));
        end
        end_stream();
        verify_outputs("random");
    endtask

    task automatic saturation_reload();
        int k;
        start_stream();
        for (k = 0; k < n_sat_old; k++) begin
            send_frame(24'h7fffff, 24'h800000);  // full scale, old coefficients
        end
        for (k = 0; k < num_taps; k++) begin
            write_coef(k, 16'(30000 + 100 * k)); // mid-stream, word clock still high
        end
        for (k = 0; k < n_sat_new; k++) begin
            send_frame(24'h7fffff, 24'h800000);
        end
        end_stream();
        verify_outputs("saturation");
        k = n_sat_old + n_sat_new;
        if (out_l.size() == k + 1 && out_r.size() == k + 1) begin
            compare_value(out_l[k], 24'h7fffff, "left clamps high");
            compare_value(out_r[k], 24'h800000, "right clamps low");
        end
    endtask

    initial begin
        void'($urandom(32'h6e97_55f2));
        arst_n     = 1'b0;
        bypass     = 1'b0;
        i2s_bclk   = 1'b0;
        i2s_lrclk  = 1'b0;
        i2s_d      = 1'b0;
        coef_we    = 1'b0;
        coef_waddr = '0;
        coef_wdata = '0;
        check_errs = 0;
        other_errs = 0;
        src_lr     = 1'b0;
        dec_lr     = 1'b0;
        dec_bclk   = 1'b0;
        dec_cnt    = 0;
        dec_word   = '0;
        pend_l     = '0;
        pend_r     = '0;
        carry_l    = '0;                       // holding registers clear at reset
        carry_r    = '0;
        for (int k = 0; k < num_taps; k++) begin
            coef_m[k] = 0;                     // store clears at reset
        end
        reset_behavior();
        impulse_response();
        bypass_path();
        random_audio();
        saturation_reload();
        $display("done: %0d value mismatches, %0d other errors", check_errs, other_errs);
        if (check_errs == 0 && other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/audio_pkg.sv
logic/i2s_rx.sv
logic/coef_ram.sv
logic/fir_filter.sv
logic/i2s_tx.sv
logic/audio_processing.sv
sim/tb_audio_processing.sv
